// File: rsv_tests.txt
# name op dst rs1 rs2 imm(hex) expected(hex), one instruction per line in dispatch order
# registers are physical numbers 0..15, LI ignores rs1 and rs2
li_p1          LI   1  0  0  005  00000005
li_p2          LI   2  0  0  003  00000003
li_p3          LI   3  0  0  a5c  00000a5c
li_p4          LI   4  0  0  0ff  000000ff
bypass_add     ADD  5  1  2  000  00000008
capture_and    AND  6  3  4  000  0000005c
sub_reg        SUB  7  1  2  000  00000002
or_reg         OR   8  3  2  000  00000a5f
xor_reg        XOR  9  3  4  000  00000aa3
sll_reg        SLL 10  1  2  000  00000028
sub_neg        SUB 11  2  1  000  fffffffe
chain_0        ADD 12 11  1  000  00000003
chain_1        SLL 13 12  2  000  00000018
chain_2        XOR 14 13  9  000  00000abb
chain_3        SUB 15 14  5  000  00000ab3
wait_add       ADD  1 15  2  000  00000ab6
wait_and       AND  2 15  4  000  000000b3
wait_or        OR   3 15 10  000  00000abb
wait_xor       XOR  4 15  6  000  00000aef
wait_sub       SUB  5 15  7  000  00000ab1
wait_sll       SLL  6 15  7  000  00002acc
indep_li       LI   8  0  0  777  00000777
indep_add      ADD  9 10  7  000  0000002a
indep_xor      XOR  0 10 11  000  ffffffd6
final_add      ADD  7  1  2  000  00000b69

// File: ooo_core_top.f
rsv_pkg.sv
priority_encoder.sv
dispatch_stage.sv
rsv.sv
int_unit.sv
ooo_core_top.sv
ooo_core_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ooo_core_top_tb
FILELIST  ?= ooo_core_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

PASS_MSG = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ooo_core_top_tb.sv
/* Reads rsv_tests.txt from the project root. Results are matched by tag,
   so any completion order is accepted. */
`default_nettype none

module ooo_core_top_tb import rsv_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT  = 200;
    localparam int NUM_TAGS    = 1 << TAG_W;

    logic    clk;
    logic    rst;
    logic    instr_valid;
    instr_t  instr;
    logic    busy;
    logic    result_valid;
    result_t result;

    string                exp_name [NUM_TAGS];
    logic [PREG_W-1:0]    exp_dst [NUM_TAGS];
    logic [XLEN-1:0]      exp_value [NUM_TAGS];
    logic [NUM_TAGS-1:0]  outstanding;
    logic [NUM_PREGS-1:0] pending;
    logic                 busy_seen;
    int                   sent_count;
    int                   seen_count;
    integer               seed;

    ooo_core_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Mismatch %s: expected 0x%08h, actual 0x%08h",
                                    name, expected, actual));
        end
    endtask

    task automatic parse_op(input string op_name, output alu_op_e op);
        op = OP_ADD;
        case (op_name)
            "ADD":   op = OP_ADD;
            "SUB":   op = OP_SUB;
            "AND":   op = OP_AND;
            "OR":    op = OP_OR;
            "XOR":   op = OP_XOR;
            "SLL":   op = OP_SLL;
            "LI":    op = OP_LI;
            default: stop_on_error($sformatf("Unknown opcode %s in the tests file", op_name));
        endcase
    endtask

    // One writer per register in flight, and a tag is reused only once it has returned
    task automatic send_instr(input string name, input alu_op_e op, input int dst,
                              input int rs1, input int rs2, input int imm,
                              input logic [31:0] expected);
        int               waited;
        logic [TAG_W-1:0] tag;
        tag    = TAG_W'(sent_count);
        waited = 0;
        while (busy || pending[dst] || outstanding[tag]) begin
            instr_valid = 1'b0;
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error($sformatf("Timed out waiting to dispatch %s", name));
            end
        end
        exp_name[tag]    = name;
        exp_dst[tag]     = PREG_W'(dst);
        exp_value[tag]   = expected;
        outstanding[tag] = 1'b1;
        pending[dst]     = 1'b1;
        instr.op  = op;
        instr.dst = PREG_W'(dst);
        instr.rs1 = PREG_W'(rs1);
        instr.rs2 = PREG_W'(rs2);
        instr.imm = IMM_W'(imm);
        // LI sources are don't-care
        if (op == OP_LI) begin
            instr.rs1 = PREG_W'($random(seed));
            instr.rs2 = PREG_W'($random(seed));
        end
        instr_valid = 1'b1;
        sent_count++;
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid = 1'b0;
    endtask

    task automatic record_result(input result_t r);
        if (!outstanding[r.tag]) begin
            stop_on_error($sformatf("Result with tag %0d arrived with no instruction on that tag",
                                    r.tag));
        end else begin
            check_value({exp_name[r.tag], " dst"}, 32'(exp_dst[r.tag]), 32'(r.dst));
            check_value({exp_name[r.tag], " value"}, exp_value[r.tag], r.value);
            outstanding[r.tag] = 1'b0;
            pending[r.dst]     = 1'b0;
            seen_count++;
        end
    endtask

    // Mid-cycle sampling of the broadcast
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            record_result(result);
        end
        if (!rst && busy) begin
            busy_seen = 1'b1;
        end
    end

    initial begin
        int          fd;
        int          fields;
        int          dst;
        int          rs1;
        int          rs2;
        int          imm;
        int          waited;
        string       line;
        string       name;
        string       op_name;
        logic [31:0] expected;
        alu_op_e     op;
        seed        = 32'h854d;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        sent_count  = 0;
        seen_count  = 0;
        outstanding = '0;
        pending     = '0;
        busy_seen   = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        // Empty station after reset
        check_value("busy_after_reset", 32'd0, 32'(busy));

        fd = $fopen("rsv_tests.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open rsv_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %s %d %d %d %h %h",
                                 name, op_name, dst, rs1, rs2, imm, expected);
                if (fields != 7) begin
                    stop_on_error($sformatf("Malformed line in the tests file: %s", line));
                end
                parse_op(op_name, op);
                send_instr(name, op, dst, rs1, rs2, imm, expected);
            end
        end
        $fclose(fd);

        waited = 0;
        while (outstanding != '0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        // A few quiet cycles so a duplicate result would still be caught
        waited = 0;
        while (waited < 8) begin
            @(posedge clk);
            waited++;
        end
        // The waiting run fills the station up to the busy level
        check_value("station_fill busy", 32'd1, 32'(busy_seen));
        if (outstanding == '0 && seen_count == sent_count) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_on_error($sformatf("Timed out with %0d of %0d results received",
                                    seen_count, sent_count));
        end
    end

endmodule

`default_nettype wire

// File: ooo_core_top.sv
/* Drive instr_valid only while busy is low. Results may return out of
   order and are matched by tag. */
`default_nettype none

module ooo_core_top import rsv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    instr_valid,
    input  instr_t  instr,
    output logic    busy,
    output logic    result_valid,
    output result_t result
);

    logic      rs_wr_valid;
    dispatch_t rs_wr;
    logic      iss_valid;
    issue_t    iss;
    logic      res_valid;
    result_t   res;

    dispatch_stage dispatch_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .res_valid   (res_valid),
        .res         (res),
        .rs_wr_valid (rs_wr_valid),
        .rs_wr       (rs_wr)
    );

    rsv rsv_i (
        .clk         (clk),
        .rst         (rst),
        .rs_wr_valid (rs_wr_valid),
        .rs_wr       (rs_wr),
        .res_valid   (res_valid),
        .res         (res),
        .iss_valid   (iss_valid),
        .iss         (iss),
        .busy        (busy)
    );

    int_unit int_unit_i (
        .clk       (clk),
        .rst       (rst),
        .iss_valid (iss_valid),
        .iss       (iss),
        .res_valid (res_valid),
        .res       (res)
    );

    // Broadcast also leaves the core
    assign result_valid = res_valid;
    assign result       = res;

endmodule

`default_nettype wire

// File: int_unit.sv
/* Single-cycle ALU, always accepts. LI zero-extends the immediate. */
`default_nettype none

module int_unit import rsv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    iss_valid,
    input  issue_t  iss,
    output logic    res_valid,
    output result_t res
);

    logic [XLEN-1:0] alu_out;

    always_comb begin
        case (iss.op)
            OP_ADD:  alu_out = iss.rs1_val + iss.rs2_val;
            OP_SUB:  alu_out = iss.rs1_val - iss.rs2_val;
            OP_AND:  alu_out = iss.rs1_val & iss.rs2_val;
            OP_OR:   alu_out = iss.rs1_val | iss.rs2_val;
            OP_XOR:  alu_out = iss.rs1_val ^ iss.rs2_val;
            // Shift amount from low 5 bits
            OP_SLL:  alu_out = iss.rs1_val << iss.rs2_val[4:0];
            OP_LI:   alu_out = {{(XLEN - IMM_W){1'b0}}, iss.imm};
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            res.tag   <= iss.tag;
            res.dst   <= iss.dst;
            res.value <= alu_out;
        end
    end

    // Opcode has travelled through dispatch and the station
    a_legal_op: assert property (
        @(posedge clk) disable iff (rst)
        iss_valid |-> iss.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_LI}
    );

endmodule

`default_nettype wire

// File: rsv.sv
/* Issues one ready entry per cycle, lowest slot first, with no age order.
   busy rises while fewer than two slots are free, one being for the dispatch register. */
`default_nettype none

module rsv import rsv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rs_wr_valid,
    input  dispatch_t rs_wr,
    input  logic      res_valid,
    input  result_t   res,
    output logic      iss_valid,
    output issue_t    iss,
    output logic      busy
);

    dispatch_t             slots [RSV_SIZE];
    logic [RSV_SIZE-1:0]   occupied;
    logic [RSV_SIZE-1:0]   free_vec;
    logic [RSV_SIZE-1:0]   rdy_vec;
    logic [RSV_SIZE-1:0]   wake1;
    logic [RSV_SIZE-1:0]   wake2;
    logic [RSV_IDX_W-1:0]  alloc_idx;
    logic [RSV_IDX_W-1:0]  issue_idx;
    logic                  alloc_none;
    logic                  issue_none;
    logic [RSV_IDX_W:0]    free_cnt;
    dispatch_t             wr_entry;

    assign free_vec = ~occupied;

    always_comb begin
        for (int i = 0; i < RSV_SIZE; i++) begin
            rdy_vec[i] = occupied[i] & slots[i].rs1_ready & slots[i].rs2_ready;
            wake1[i]   = res_valid & occupied[i] & !slots[i].rs1_ready &
                         (slots[i].rs1 == res.dst);
            wake2[i]   = res_valid & occupied[i] & !slots[i].rs2_ready &
                         (slots[i].rs2 == res.dst);
        end
    end

    // Incoming entry also sees this cycle's broadcast
    always_comb begin
        wr_entry = rs_wr;
        if (res_valid && !rs_wr.rs1_ready && rs_wr.rs1 == res.dst) begin
            wr_entry.rs1_ready = 1'b1;
            wr_entry.rs1_val   = res.value;
        end
        if (res_valid && !rs_wr.rs2_ready && rs_wr.rs2 == res.dst) begin
            wr_entry.rs2_ready = 1'b1;
            wr_entry.rs2_val   = res.value;
        end
    end

    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < RSV_SIZE; i++) begin
            free_cnt = free_cnt + {{RSV_IDX_W{1'b0}}, free_vec[i]};
        end
    end

    assign busy = (free_cnt < 2);

    priority_encoder #(
        .WIDTH (RSV_SIZE)
    ) alloc_enc_i (
        .req  (free_vec),
        .idx  (alloc_idx),
        .none (alloc_none)
    );

    priority_encoder #(
        .WIDTH (RSV_SIZE)
    ) issue_enc_i (
        .req  (rdy_vec),
        .idx  (issue_idx),
        .none (issue_none)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupied  <= '0;
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= !issue_none;
            if (!issue_none) begin
                occupied[issue_idx] <= 1'b0;
            end
            if (rs_wr_valid && !alloc_none) begin
                occupied[alloc_idx] <= 1'b1;
            end
        end
    end

    // Entry storage and wake-up
    always_ff @(posedge clk) begin
        for (int i = 0; i < RSV_SIZE; i++) begin
            if (wake1[i]) begin
                slots[i].rs1_ready <= 1'b1;
                slots[i].rs1_val   <= res.value;
            end
            if (wake2[i]) begin
                slots[i].rs2_ready <= 1'b1;
                slots[i].rs2_val   <= res.value;
            end
        end
        if (rs_wr_valid && !alloc_none) begin
            slots[alloc_idx] <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!issue_none) begin
            iss.tag     <= slots[issue_idx].tag;
            iss.op      <= slots[issue_idx].op;
            iss.dst     <= slots[issue_idx].dst;
            iss.imm     <= slots[issue_idx].imm;
            iss.rs1_val <= slots[issue_idx].rs1_val;
            iss.rs2_val <= slots[issue_idx].rs2_val;
        end
    end

    // Dispatch must respect busy
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst) rs_wr_valid |-> !alloc_none
    );

    // Selected slot holds both operands and no lower slot is ready
    a_issue_operands: assert property (
        @(posedge clk) disable iff (rst)
        !issue_none |-> rdy_vec[issue_idx] &&
            ((rdy_vec & ((RSV_SIZE'(1) << issue_idx) - 1'b1)) == '0)
    );

endmodule

`default_nettype wire

// File: dispatch_stage.sv
/* No renaming, so two outstanding writers of one register are not allowed.
   A same-cycle broadcast is bypassed into the operand read. */
`default_nettype none

module dispatch_stage import rsv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  instr_t    instr,
    input  logic      res_valid,
    input  result_t   res,
    output logic      rs_wr_valid,
    output dispatch_t rs_wr
);

    logic [XLEN-1:0]      regs [NUM_PREGS];
    logic [NUM_PREGS-1:0] ready;
    logic [TAG_W-1:0]     tag_q;
    dispatch_t            entry;

    // Operand read with broadcast bypass
    always_comb begin
        entry.tag = tag_q;
        entry.op  = instr.op;
        entry.dst = instr.dst;
        entry.rs1 = instr.rs1;
        entry.rs2 = instr.rs2;
        entry.imm = instr.imm;

        if (res_valid && res.dst == instr.rs1) begin
            entry.rs1_ready = 1'b1;
            entry.rs1_val   = res.value;
        end else begin
            entry.rs1_ready = ready[instr.rs1];
            entry.rs1_val   = regs[instr.rs1];
        end

        if (res_valid && res.dst == instr.rs2) begin
            entry.rs2_ready = 1'b1;
            entry.rs2_val   = res.value;
        end else begin
            entry.rs2_ready = ready[instr.rs2];
            entry.rs2_val   = regs[instr.rs2];
        end

        // Sources unused by a load-immediate
        if (instr.op == OP_LI) begin
            entry.rs1_ready = 1'b1;
            entry.rs2_ready = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready       <= '1;
            tag_q       <= '0;
            rs_wr_valid <= 1'b0;
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            rs_wr_valid <= instr_valid;
            if (instr_valid) begin
                tag_q <= tag_q + 1'b1;
                if (!(res_valid && res.dst == instr.dst)) begin
                    ready[instr.dst] <= 1'b0;
                end
            end
            // Writeback
            if (res_valid) begin
                regs[res.dst]  <= res.value;
                ready[res.dst] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            rs_wr <= entry;
        end
    end

    // Only a pending register may be written back
    a_bcast_pending: assert property (
        @(posedge clk) disable iff (rst) res_valid |-> !ready[res.dst]
    );

endmodule

`default_nettype wire

// File: priority_encoder.sv
/* Lowest set bit wins. WIDTH must be a power of two, at least 2. */
`default_nettype none

module priority_encoder import rsv_pkg::*; #(
    parameter int WIDTH = RSV_SIZE
) (
    input  logic [WIDTH-1:0]         req,
    output logic [$clog2(WIDTH)-1:0] idx,
    output logic                     none
);

    // Scan downward so the lowest index overrides the rest
    always_comb begin
        idx  = '0;
        none = 1'b1;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx  = i[$clog2(WIDTH)-1:0];
                none = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rsv_pkg.sv
/* Shared widths and bus types of the execution slice.
   Physical register numbers arrive already renamed, so no mapping lives here. */
`default_nettype none

package rsv_pkg;

    localparam int XLEN      = 32;
    localparam int PREG_W    = 4;
    localparam int NUM_PREGS = 1 << PREG_W;
    localparam int TAG_W     = 4;
    localparam int RSV_SIZE  = 8;
    localparam int RSV_IDX_W = 3;
    localparam int IMM_W     = 12;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_LI
    } alu_op_e;

    // Top-level instruction as it enters dispatch
    typedef struct packed {
        alu_op_e           op;
        logic [PREG_W-1:0] dst;
        logic [PREG_W-1:0] rs1;
        logic [PREG_W-1:0] rs2;
        logic [IMM_W-1:0]  imm;
    } instr_t;

    // One station entry
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        alu_op_e           op;
        logic [PREG_W-1:0] dst;
        logic [PREG_W-1:0] rs1;
        logic              rs1_ready;
        logic [XLEN-1:0]   rs1_val;
        logic [PREG_W-1:0] rs2;
        logic              rs2_ready;
        logic [XLEN-1:0]   rs2_val;
        logic [IMM_W-1:0]  imm;
    } dispatch_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        alu_op_e           op;
        logic [PREG_W-1:0] dst;
        logic [IMM_W-1:0]  imm;
        logic [XLEN-1:0]   rs1_val;
        logic [XLEN-1:0]   rs2_val;
    } issue_t;

    // Result broadcast
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [PREG_W-1:0] dst;
        logic [XLEN-1:0]   value;
    } result_t;

endpackage

`default_nettype wire
